// ==== build.f ====
rtl/periph_bus_pkg.sv
rtl/periph_map_pkg.sv
rtl/wb_reg_bridge.sv
rtl/periph_decode.sv
rtl/gpio_regs.sv
rtl/timer_regs.sv
rtl/irq_gather.sv
rtl/peripheral_subsystem.sv
bench/tb_peripheral_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exits non-zero on failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_peripheral_subsystem --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

// ==== bench/tb_peripheral_subsystem.sv ====
// ################################################
// Directed tests at default GPIO_W 8, N_EXT_IRQ 4;
// random bus data from $urandom with seed 39
// ################################################
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  localparam int GPIO_W      = 8;
  localparam int N_EXT       = 4;
  localparam int BUS_TIMEOUT = 20;
  localparam int PIN         = 5;
  localparam int GPIO_ID     = periph_map_pkg::IRQ_GPIO_BASE + PIN;
  localparam int EXT_BASE    = periph_map_pkg::IRQ_GPIO_BASE + GPIO_W;
  localparam logic [31:0] GPIO_MASK = (32'd1 << GPIO_W) - 32'd1;

  function automatic logic [31:0] reg_addr(input periph_map_pkg::idx_t idx,
                                           input periph_map_pkg::reg_off_t off);
    logic [31:0] a;
    a = 32'(idx) << periph_map_pkg::PERIPH_SEL_LSB;
    return a | (32'(off) << periph_map_pkg::REG_OFF_LSB);
  endfunction

  localparam logic [31:0] GPIO_IN_A  = reg_addr(periph_map_pkg::GPIO_IDX, 2'd0);
  localparam logic [31:0] GPIO_OUT_A = reg_addr(periph_map_pkg::GPIO_IDX, 2'd1);
  localparam logic [31:0] GPIO_OE_A  = reg_addr(periph_map_pkg::GPIO_IDX, 2'd2);
  localparam logic [31:0] GPIO_RISE_A = reg_addr(periph_map_pkg::GPIO_IDX, 2'd3);
  localparam logic [31:0] TMR_COUNT_A = reg_addr(periph_map_pkg::TIMER_IDX, 2'd0);
  localparam logic [31:0] TMR_CMP_A   = reg_addr(periph_map_pkg::TIMER_IDX, 2'd1);
  localparam logic [31:0] TMR_CTRL_A  = reg_addr(periph_map_pkg::TIMER_IDX, 2'd2);
  localparam logic [31:0] IRQ_PEND_A  = reg_addr(periph_map_pkg::IRQ_IDX, 2'd0);
  localparam logic [31:0] IRQ_EN_A    = reg_addr(periph_map_pkg::IRQ_IDX, 2'd1);
  localparam logic [31:0] IRQ_CLAIM_A = reg_addr(periph_map_pkg::IRQ_IDX, 2'd2);

  logic              clk_i, reset_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o, wb_err_o, irq_o;
  logic [31:0]       wb_adr_i, wb_dat_i, wb_dat_o;
  logic [3:0]        wb_sel_i;
  logic [GPIO_W-1:0] gpio_i, gpio_o, gpio_oe_o;
  logic [N_EXT-1:0]  ext_irq_i;
  int                error_count, tests_run, tests_failed;
  logic [31:0]       out_model, oe_model, compare_model;

  peripheral_subsystem i_dut (
    .clk_i, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o, .gpio_i, .gpio_o, .gpio_oe_o, .ext_irq_i, .irq_o
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // New word keeps the old bytes wherever the select bit is clear
  function automatic logic [31:0] apply_selects(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Returns at a falling edge, with stb already dropped
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                           input logic [3:0] sel, output logic [31:0] rdat,
                           output logic ack, output logic err, output int lat);
    int edges;
    edges = 0;
    ack   = 1'b0;
    err   = 1'b0;
    rdat  = '0;
    lat   = -1;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    wb_sel_i <= sel;
    while (!ack && !err && edges < BUS_TIMEOUT) begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
      if (wb_ack_o || wb_err_o) begin
        ack  = wb_ack_o;
        err  = wb_err_o;
        rdat = wb_dat_o;
        lat  = edges - 1;
      end
    end
    if (!ack && !err) begin
      $display("timeout: no ack or err for the access to address 0x%08h", adr);
      error_count++;
    end
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] data,
                          input logic [3:0] sel);
    logic [31:0] rdat;
    logic        ack, err;
    int          lat;
    bus_cycle(1'b1, adr, data, sel, rdat, ack, err, lat);
    check_value($sformatf("ack of write to 0x%08h", adr), 32'(ack && !err), 32'd1);
    check_value("write ack latency", 32'(lat), 32'd2);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
    logic ack, err;
    int   lat;
    bus_cycle(1'b0, adr, '0, 4'hF, data, ack, err, lat);
    check_value($sformatf("ack of read from 0x%08h", adr), 32'(ack && !err), 32'd1);
    check_value("read ack latency", 32'(lat), 32'd2);
  endtask

  task automatic expect_read(input string what, input logic [31:0] adr,
                             input logic [31:0] exp);
    logic [31:0] got;
    wb_read(adr, got);
    check_value(what, got, exp);
  endtask

  task automatic wait_irq(input logic level, input int limit);
    int n;
    n = 0;
    while (irq_o !== level && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (irq_o !== level) begin
      $display("timeout: irq_o did not go %s within %0d cycles", level ? "high" : "low", limit);
      error_count++;
    end
  endtask

  task automatic hold_irq_low(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      check_value("irq_o with every source disabled", 32'(irq_o), 32'd0);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic drive_pins(input logic [GPIO_W-1:0] g, input logic [N_EXT-1:0] e);
    @(posedge clk_i);
    gpio_i    <= g;
    ext_irq_i <= e;
    @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (error_count == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, error_count - start_errors);
    end
  endtask

  task automatic test_reset_state();
    int start;
    start = error_count;
    check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
    check_value("wb_err_o", 32'(wb_err_o), 32'd0);
    check_value("irq_o", 32'(irq_o), 32'd0);
    check_value("gpio_oe_o", 32'(gpio_oe_o), 32'd0);
    check_value("gpio_o", 32'(gpio_o), 32'd0);
    expect_read("OUT after reset", GPIO_OUT_A, 32'd0);
    expect_read("OE after reset", GPIO_OE_A, 32'd0);
    expect_read("COMPARE after reset", TMR_CMP_A, 32'd0);
    expect_read("ENABLE after reset", IRQ_EN_A, 32'd0);
    expect_read("CLAIM after reset", IRQ_CLAIM_A, 32'd0);
    report_test("reset_state", start);
  endtask

  task automatic test_byte_selects();
    int          start;
    logic [31:0] data, rnd;
    logic [3:0]  sel;
    start = error_count;
    for (int i = 0; i < 6; i++) begin
      // Byte 0 select alternates so both cases occur
      data = $urandom;
      rnd  = $urandom;
      sel  = {rnd[3:1], i[0]};
      wb_write(GPIO_OUT_A, data, sel);
      out_model = apply_selects(out_model, data, sel) & GPIO_MASK;
      check_value("gpio_o", 32'(gpio_o), out_model);
      expect_read("OUT readback", GPIO_OUT_A, out_model);
      data = $urandom;
      rnd  = $urandom;
      sel  = {rnd[3:1], i[0]};
      wb_write(GPIO_OE_A, data, sel);
      oe_model = apply_selects(oe_model, data, sel) & GPIO_MASK;
      check_value("gpio_oe_o", 32'(gpio_oe_o), oe_model);
      expect_read("OE readback", GPIO_OE_A, oe_model);
    end
    report_test("byte_selects", start);
  endtask

  task automatic test_gpio_events();
    int start;
    start = error_count;
    drive_pins(GPIO_W'(8'hA5), '0);
    idle_cycles(3);
    expect_read("IN after sync", GPIO_IN_A, 32'h0000_00A5);
    drive_pins('0, '0);
    idle_cycles(3);
    wb_write(GPIO_RISE_A, 32'd1 << PIN, 4'hF);
    wb_write(IRQ_EN_A, 32'd1 << GPIO_ID, 4'hF);
    drive_pins(GPIO_W'(1) << PIN, '0);
    wait_irq(1'b1, 20);
    expect_read("CLAIM for GPIO edge", IRQ_CLAIM_A, 32'(GPIO_ID));
    wb_write(IRQ_PEND_A, 32'd1 << GPIO_ID, 4'hF);
    wait_irq(1'b0, 10);
    expect_read("PENDING after clear", IRQ_PEND_A, 32'd0);
    wb_write(GPIO_RISE_A, 32'd0, 4'hF);
    wb_write(IRQ_EN_A, 32'd0, 4'hF);
    drive_pins('0, '0);
    report_test("gpio_events", start);
  endtask

  task automatic test_timer_irq();
    int start;
    start = error_count;
    wb_write(TMR_COUNT_A, 32'd100, 4'hF);
    wb_write(TMR_CMP_A, 32'd140, 4'hF);
    compare_model = 32'd140;
    wb_write(IRQ_EN_A, 32'd1 << periph_map_pkg::IRQ_TIMER_ID, 4'hF);
    wb_write(TMR_CTRL_A, 32'd1, 4'hF);
    check_value("irq_o before match", 32'(irq_o), 32'd0);
    wait_irq(1'b1, 200);
    expect_read("CLAIM for timer", IRQ_CLAIM_A, 32'(periph_map_pkg::IRQ_TIMER_ID));
    wb_write(TMR_CTRL_A, 32'd0, 4'hF);
    wb_write(IRQ_PEND_A, 32'd1 << periph_map_pkg::IRQ_TIMER_ID, 4'hF);
    wb_write(IRQ_EN_A, 32'd0, 4'hF);
    wait_irq(1'b0, 10);
    report_test("timer_irq", start);
  endtask

  task automatic test_irq_priority();
    int start;
    start = error_count;
    wb_write(IRQ_EN_A, 32'hF << EXT_BASE, 4'hF);
    drive_pins('0, 4'b1010);
    wait_irq(1'b1, 20);
    expect_read("CLAIM lower ID", IRQ_CLAIM_A, 32'(EXT_BASE + 1));
    wb_write(IRQ_EN_A, 32'd1 << (EXT_BASE + 3), 4'hF);
    expect_read("CLAIM with lower ID masked", IRQ_CLAIM_A, 32'(EXT_BASE + 3));
    wb_write(IRQ_EN_A, 32'd0, 4'hF);
    hold_irq_low(5);
    // A fresh edge while everything is masked
    drive_pins('0, 4'b1011);
    hold_irq_low(20);
    expect_read("CLAIM with all masked", IRQ_CLAIM_A, 32'd0);
    drive_pins('0, '0);
    wb_write(IRQ_PEND_A, 32'hFFFF_FFFF, 4'hF);
    report_test("irq_priority", start);
  endtask

  task automatic test_unmapped_access();
    int          start, lat;
    logic [31:0] rdat;
    logic        ack, err;
    start = error_count;
    // Index 3 and index 13 are unmapped, 13 shares its low two bits with the timer
    bus_cycle(1'b0, 32'h0000_3004, '0, 4'hF, rdat, ack, err, lat);
    check_value("err on unmapped read", 32'({ack, err}), 32'b01);
    check_value("data on unmapped read", rdat, 32'd0);
    check_value("err latency", 32'(lat), 32'd2);
    bus_cycle(1'b1, 32'h0000_3004, 32'hFFFF_FFFF, 4'hF, rdat, ack, err, lat);
    check_value("err on unmapped write", 32'({ack, err}), 32'b01);
    bus_cycle(1'b1, 32'h0000_D008, 32'hFFFF_FFFF, 4'hF, rdat, ack, err, lat);
    check_value("err on unmapped write", 32'({ack, err}), 32'b01);
    expect_read("OUT after unmapped", GPIO_OUT_A, out_model);
    expect_read("OE after unmapped", GPIO_OE_A, oe_model);
    expect_read("RISE_EN after unmapped", GPIO_RISE_A, 32'd0);
    expect_read("COMPARE after unmapped", TMR_CMP_A, compare_model);
    expect_read("CTRL after unmapped", TMR_CTRL_A, 32'd0);
    expect_read("ENABLE after unmapped", IRQ_EN_A, 32'd0);
    report_test("unmapped_access", start);
  endtask

  initial begin
    void'($urandom(39));
    error_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    out_model     = '0;
    oe_model      = '0;
    compare_model = '0;
    reset_i   = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    gpio_i    = '0;
    ext_irq_i = '0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    test_reset_state();
    test_byte_selects();
    test_gpio_events();
    test_timer_irq();
    test_irq_priority();
    test_unmapped_access();
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== rtl/peripheral_subsystem.sv ====
// ################################################
// Wishbone peripheral subsystem; ext_irq_i lines
// are taken as already synchronous to clk_i
// ################################################
`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int GPIO_W    = 8,
  parameter int N_EXT_IRQ = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  periph_bus_pkg::addr_t wb_adr_i,
  input  periph_bus_pkg::data_t wb_dat_i,
  input  periph_bus_pkg::sel_t  wb_sel_i,
  output periph_bus_pkg::data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  input  logic [GPIO_W-1:0]     gpio_i,
  output logic [GPIO_W-1:0]     gpio_o,
  output logic [GPIO_W-1:0]     gpio_oe_o,
  input  logic [N_EXT_IRQ-1:0]  ext_irq_i,
  output logic                  irq_o
);

  logic                  reg_valid, reg_write, reg_error;
  periph_bus_pkg::addr_t reg_addr;
  periph_bus_pkg::data_t reg_wdata, reg_rdata;
  periph_bus_pkg::sel_t  reg_be;
  logic                  gpio_valid, timer_valid, irq_valid;
  periph_bus_pkg::data_t gpio_rdata, timer_rdata, irq_rdata;
  logic [GPIO_W-1:0]     gpio_rise;
  logic                  timer_match;

  wb_reg_bridge i_bridge (
    .clk_i, .reset_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o,
    .reg_valid_o(reg_valid), .reg_write_o(reg_write), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_be_o(reg_be),
    .reg_rdata_i(reg_rdata), .reg_error_i(reg_error)
  );

  periph_decode i_decode (
    .reg_valid_i(reg_valid), .reg_addr_i(reg_addr),
    .gpio_valid_o(gpio_valid), .timer_valid_o(timer_valid), .irq_valid_o(irq_valid),
    .gpio_rdata_i(gpio_rdata), .timer_rdata_i(timer_rdata), .irq_rdata_i(irq_rdata),
    .reg_rdata_o(reg_rdata), .reg_error_o(reg_error)
  );

  gpio_regs #(.GPIO_W(GPIO_W)) i_gpio (
    .clk_i, .reset_i,
    .valid_i(gpio_valid), .write_i(reg_write), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .be_i(reg_be), .rdata_o(gpio_rdata),
    .gpio_i, .gpio_o, .gpio_oe_o, .rise_o(gpio_rise)
  );

  timer_regs i_timer (
    .clk_i, .reset_i,
    .valid_i(timer_valid), .write_i(reg_write), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .be_i(reg_be), .rdata_o(timer_rdata),
    .match_o(timer_match)
  );

  irq_gather #(.GPIO_W(GPIO_W), .N_EXT_IRQ(N_EXT_IRQ)) i_irq (
    .clk_i, .reset_i,
    .valid_i(irq_valid), .write_i(reg_write), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .be_i(reg_be), .rdata_o(irq_rdata),
    .timer_i(timer_match), .gpio_i(gpio_rise), .ext_i(ext_irq_i), .irq_o
  );

endmodule

// ==== rtl/irq_gather.sv ====
// ################################################
// Rising-edge interrupt collector, at most 32 IDs;
// ID 0 never pends, CLAIM reads lowest active ID
// ################################################
`timescale 1ns/1ps

module irq_gather #(
  parameter int GPIO_W    = 8,
  parameter int N_EXT_IRQ = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic                  write_i,
  input  periph_bus_pkg::addr_t addr_i,
  input  periph_bus_pkg::data_t wdata_i,
  input  periph_bus_pkg::sel_t  be_i,
  output periph_bus_pkg::data_t rdata_o,
  input  logic                  timer_i,
  input  logic [GPIO_W-1:0]     gpio_i,
  input  logic [N_EXT_IRQ-1:0]  ext_i,
  output logic                  irq_o
);

  localparam int EXT_BASE = periph_map_pkg::IRQ_GPIO_BASE + GPIO_W;
  localparam int N_SRC    = EXT_BASE + N_EXT_IRQ;
  localparam int ID_W     = $clog2(N_SRC);

  typedef logic [ID_W-1:0] id_t;

  periph_map_pkg::reg_off_t off;
  logic                     wr;
  logic [N_SRC-1:0]         src, src_q, pending_q, enable_q, active, clr;
  periph_bus_pkg::data_t    clr_word, enable_next;
  id_t                      claim_id;

  assign off = addr_i[periph_map_pkg::REG_OFF_LSB +: 2];
  assign wr  = valid_i && write_i;

  assign src[0]                                          = 1'b0;
  assign src[periph_map_pkg::IRQ_TIMER_ID]               = timer_i;
  assign src[periph_map_pkg::IRQ_GPIO_BASE +: GPIO_W]    = gpio_i;
  assign src[EXT_BASE +: N_EXT_IRQ]                      = ext_i;

  // Write-one-to-clear mask, limited to selected bytes
  assign clr_word    = periph_bus_pkg::be_merge('0, wdata_i, be_i);
  assign clr         = (wr && off == periph_map_pkg::IRQ_PENDING_OFF) ? clr_word[N_SRC-1:0] : '0;
  assign enable_next = periph_bus_pkg::be_merge(periph_bus_pkg::data_t'(enable_q), wdata_i, be_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      irq_o     <= 1'b0;
    end else begin
      src_q     <= src;
      pending_q <= (pending_q & ~clr) | (src & ~src_q);
      if (wr && off == periph_map_pkg::IRQ_ENABLE_OFF) enable_q <= enable_next[N_SRC-1:0];
      irq_o <= |active;
    end
  end

  assign active = pending_q & enable_q;

  always_comb begin
    claim_id = '0;
    for (int i = N_SRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = id_t'(i);
    end
  end

  always_comb begin
    case (off)
      periph_map_pkg::IRQ_PENDING_OFF: rdata_o = periph_bus_pkg::data_t'(pending_q);
      periph_map_pkg::IRQ_ENABLE_OFF:  rdata_o = periph_bus_pkg::data_t'(enable_q);
      periph_map_pkg::IRQ_CLAIM_OFF:   rdata_o = periph_bus_pkg::data_t'(claim_id);
      default:                         rdata_o = '0;
    endcase
  end

endmodule

// ==== rtl/timer_regs.sv ====
// ################################################
// 32-bit up counter; a COUNT write wins over the
// increment in the same cycle
// ################################################
`timescale 1ns/1ps

module timer_regs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic                  write_i,
  input  periph_bus_pkg::addr_t addr_i,
  input  periph_bus_pkg::data_t wdata_i,
  input  periph_bus_pkg::sel_t  be_i,
  output periph_bus_pkg::data_t rdata_o,
  output logic                  match_o
);

  periph_map_pkg::reg_off_t off;
  logic                     wr;
  periph_bus_pkg::data_t    count_q, compare_q;
  logic                     en_q;

  assign off = addr_i[periph_map_pkg::REG_OFF_LSB +: 2];
  assign wr  = valid_i && write_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q   <= '0;
      compare_q <= '0;
      en_q      <= 1'b0;
    end else begin
      if (wr && off == periph_map_pkg::TMR_COUNT_OFF) begin
        count_q <= periph_bus_pkg::be_merge(count_q, wdata_i, be_i);
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && off == periph_map_pkg::TMR_COMPARE_OFF) begin
        compare_q <= periph_bus_pkg::be_merge(compare_q, wdata_i, be_i);
      end
      // Only bit 0 of CTRL exists
      if (wr && off == periph_map_pkg::TMR_CTRL_OFF && be_i[0]) en_q <= wdata_i[0];
    end
  end

  always_comb begin
    case (off)
      periph_map_pkg::TMR_COUNT_OFF:   rdata_o = count_q;
      periph_map_pkg::TMR_COMPARE_OFF: rdata_o = compare_q;
      periph_map_pkg::TMR_CTRL_OFF:    rdata_o = {{(periph_bus_pkg::DATA_W-1){1'b0}}, en_q};
      default:                         rdata_o = '0;
    endcase
  end

  assign match_o = en_q && (count_q == compare_q);

endmodule

// ==== rtl/gpio_regs.sv ====
// ################################################
// GPIO block, GPIO_W up to 32; inputs pass a two
// flop synchronizer before IN and edge detection
// ################################################
`timescale 1ns/1ps

module gpio_regs #(
  parameter int GPIO_W = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic                  write_i,
  input  periph_bus_pkg::addr_t addr_i,
  input  periph_bus_pkg::data_t wdata_i,
  input  periph_bus_pkg::sel_t  be_i,
  output periph_bus_pkg::data_t rdata_o,
  input  logic [GPIO_W-1:0]     gpio_i,
  output logic [GPIO_W-1:0]     gpio_o,
  output logic [GPIO_W-1:0]     gpio_oe_o,
  output logic [GPIO_W-1:0]     rise_o
);

  periph_map_pkg::reg_off_t off;
  logic                     wr;
  logic [GPIO_W-1:0]        sync1_q, in_q, in_prev_q;
  logic [GPIO_W-1:0]        out_q, oe_q, rise_en_q, rise_q;
  periph_bus_pkg::data_t    out_next, oe_next, rise_en_next;

  assign off = addr_i[periph_map_pkg::REG_OFF_LSB +: 2];
  assign wr  = valid_i && write_i;

  assign out_next     = periph_bus_pkg::be_merge(periph_bus_pkg::data_t'(out_q), wdata_i, be_i);
  assign oe_next      = periph_bus_pkg::be_merge(periph_bus_pkg::data_t'(oe_q), wdata_i, be_i);
  assign rise_en_next = periph_bus_pkg::be_merge(periph_bus_pkg::data_t'(rise_en_q), wdata_i,
                                                 be_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q   <= '0;
      in_q      <= '0;
      in_prev_q <= '0;
      rise_q    <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      rise_en_q <= '0;
    end else begin
      sync1_q   <= gpio_i;
      in_q      <= sync1_q;
      in_prev_q <= in_q;
      rise_q    <= in_q & ~in_prev_q & rise_en_q;
      if (wr && off == periph_map_pkg::GPIO_OUT_OFF)     out_q     <= out_next[GPIO_W-1:0];
      if (wr && off == periph_map_pkg::GPIO_OE_OFF)      oe_q      <= oe_next[GPIO_W-1:0];
      if (wr && off == periph_map_pkg::GPIO_RISE_EN_OFF) rise_en_q <= rise_en_next[GPIO_W-1:0];
    end
  end

  always_comb begin
    case (off)
      periph_map_pkg::GPIO_IN_OFF:  rdata_o = periph_bus_pkg::data_t'(in_q);
      periph_map_pkg::GPIO_OUT_OFF: rdata_o = periph_bus_pkg::data_t'(out_q);
      periph_map_pkg::GPIO_OE_OFF:  rdata_o = periph_bus_pkg::data_t'(oe_q);
      default:                      rdata_o = periph_bus_pkg::data_t'(rise_en_q);
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign rise_o    = rise_q;

endmodule

// ==== rtl/periph_decode.sv ====
// ################################################
// Combinational decode; unmapped index gives error
// ################################################
`timescale 1ns/1ps

module periph_decode (
  input  logic                  reg_valid_i,
  input  periph_bus_pkg::addr_t reg_addr_i,
  output logic                  gpio_valid_o,
  output logic                  timer_valid_o,
  output logic                  irq_valid_o,
  input  periph_bus_pkg::data_t gpio_rdata_i,
  input  periph_bus_pkg::data_t timer_rdata_i,
  input  periph_bus_pkg::data_t irq_rdata_i,
  output periph_bus_pkg::data_t reg_rdata_o,
  output logic                  reg_error_o
);

  logic [periph_map_pkg::PERIPH_SEL_W-1:0] sel_field;
  periph_map_pkg::idx_t                    idx;
  logic                                    mapped;

  assign sel_field = reg_addr_i[periph_map_pkg::PERIPH_SEL_LSB +: periph_map_pkg::PERIPH_SEL_W];
  assign mapped    = (sel_field < periph_map_pkg::NUM_PERIPH);
  assign idx       = periph_map_pkg::idx_t'(sel_field);

  always_comb begin
    gpio_valid_o  = 1'b0;
    timer_valid_o = 1'b0;
    irq_valid_o   = 1'b0;
    reg_rdata_o   = '0;
    if (mapped) begin
      case (idx)
        periph_map_pkg::GPIO_IDX: begin
          gpio_valid_o = reg_valid_i;
          reg_rdata_o  = gpio_rdata_i;
        end
        periph_map_pkg::TIMER_IDX: begin
          timer_valid_o = reg_valid_i;
          reg_rdata_o   = timer_rdata_i;
        end
        periph_map_pkg::IRQ_IDX: begin
          irq_valid_o = reg_valid_i;
          reg_rdata_o = irq_rdata_i;
        end
        default: reg_rdata_o = '0;
      endcase
    end
  end

  assign reg_error_o = reg_valid_i && !mapped;

endmodule

// ==== rtl/wb_reg_bridge.sv ====
// ################################################
// Wishbone classic slave, one transfer at a time;
// ack or err two edges after the request is sampled
// ################################################
`timescale 1ns/1ps

module wb_reg_bridge (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  periph_bus_pkg::addr_t wb_adr_i,
  input  periph_bus_pkg::data_t wb_dat_i,
  input  periph_bus_pkg::sel_t  wb_sel_i,
  output periph_bus_pkg::data_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 reg_valid_o,
  output logic                 reg_write_o,
  output periph_bus_pkg::addr_t reg_addr_o,
  output periph_bus_pkg::data_t reg_wdata_o,
  output periph_bus_pkg::sel_t  reg_be_o,
  input  periph_bus_pkg::data_t reg_rdata_i,
  input  logic                 reg_error_i
);

  typedef enum logic [1:0] {IDLE, ISSUE, RESPOND} state_e;

  state_e                state_q;
  logic                  we_q;
  periph_bus_pkg::addr_t adr_q;
  periph_bus_pkg::data_t wdat_q;
  periph_bus_pkg::sel_t  sel_q;
  periph_bus_pkg::data_t rdata_q;
  logic                  dec_err_q;
  logic                  ack_q;
  logic                  err_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      dec_err_q <= 1'b0;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      case (state_q)
        // Master still holds stb during the response cycle
        IDLE: if (wb_cyc_i && wb_stb_i && !ack_q && !err_q) state_q <= ISSUE;
        ISSUE: begin
          dec_err_q <= reg_error_i;
          state_q   <= RESPOND;
        end
        RESPOND: begin
          ack_q   <= !dec_err_q;
          err_q   <= dec_err_q;
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      we_q   <= wb_we_i;
      adr_q  <= wb_adr_i;
      wdat_q <= wb_dat_i;
      sel_q  <= wb_sel_i;
    end
    if (state_q == ISSUE) rdata_q <= reg_rdata_i;
  end

  assign reg_valid_o = (state_q == ISSUE);
  assign reg_write_o = we_q;
  assign reg_addr_o  = adr_q;
  assign reg_wdata_o = wdat_q;
  assign reg_be_o    = sel_q;

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = ack_q ? rdata_q : '0;

endmodule

// ==== rtl/periph_map_pkg.sv ====
// ################################################
// Address map and interrupt IDs; bits 15:12 pick a
// peripheral, bits 3:2 pick a word register
// ################################################

package periph_map_pkg;

  localparam int NUM_PERIPH     = 3;
  localparam int PERIPH_SEL_LSB = 12;
  localparam int PERIPH_SEL_W   = 4;
  localparam int REG_OFF_LSB    = 2;

  typedef logic [1:0] idx_t;
  typedef logic [1:0] reg_off_t;

  localparam idx_t GPIO_IDX  = 2'd0;
  localparam idx_t TIMER_IDX = 2'd1;
  localparam idx_t IRQ_IDX   = 2'd2;

  localparam reg_off_t GPIO_IN_OFF      = 2'd0;
  localparam reg_off_t GPIO_OUT_OFF     = 2'd1;
  localparam reg_off_t GPIO_OE_OFF      = 2'd2;
  localparam reg_off_t GPIO_RISE_EN_OFF = 2'd3;

  localparam reg_off_t TMR_COUNT_OFF   = 2'd0;
  localparam reg_off_t TMR_COMPARE_OFF = 2'd1;
  localparam reg_off_t TMR_CTRL_OFF    = 2'd2;

  localparam reg_off_t IRQ_PENDING_OFF = 2'd0;
  localparam reg_off_t IRQ_ENABLE_OFF  = 2'd1;
  localparam reg_off_t IRQ_CLAIM_OFF   = 2'd2;

  localparam int IRQ_TIMER_ID  = 1;
  localparam int IRQ_GPIO_BASE = 2;

endpackage

// ==== rtl/periph_bus_pkg.sv ====
// ################################################
// Register bus widths, fixed at a 32-bit data path
// ################################################

package periph_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // Replace only the bytes whose select bit is set
  function automatic data_t be_merge(data_t old_val, data_t new_val, sel_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < SEL_W; b++) begin
      if (be[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

endpackage
